// ==== all.f ====
opl_pkg.sv
pkt_fifo.sv
header_parser.sv
exact_match.sv
wildcard_match.sv
match_arbiter.sv
opl_processor.sv
output_port_lookup.sv
tb_output_port_lookup.sv

// ==== exact_match.sv ====
//////////////////////////////
// exact-match flow table, registered result
//////////////////////////////
`timescale 1ns/100ps

module exact_match (
   input  logic                            clk,
   input  logic                            reset,
   input  opl_pkg::flow_key_t              key,
   input  logic                            key_vld,
   input  logic                            tbl_wr,
   input  logic                            tbl_wildcard,
   input  logic [opl_pkg::table_idx_w-1:0] tbl_index,
   input  opl_pkg::flow_key_t              tbl_key,
   input  opl_pkg::action_t                tbl_action,
   output logic                            hit,
   output opl_pkg::action_t                action,
   output logic                            res_vld
);

   import opl_pkg::*;

   logic [exact_entries-1:0] entry_vld;
   flow_key_t                entry_key [exact_entries];
   action_t                  entry_action [exact_entries];

   logic    match_hit;
   action_t match_action;
   logic    tbl_sel;

   // writes with select low land here
   assign tbl_sel = tbl_wr && !tbl_wildcard;

   //////////////////////////////
   // table storage
   always_ff @(posedge clk) begin
      if (reset) begin
         entry_vld <= '0;
      end else if (tbl_sel) begin
         entry_vld[tbl_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (tbl_sel) begin
         entry_key[tbl_index]    <= tbl_key;
         entry_action[tbl_index] <= tbl_action;
      end
   end

   //////////////////////////////
   // search
   // walk down so the lowest index wins
   always_comb begin
      match_hit    = 1'b0;
      match_action = '0;
      for (int i = exact_entries - 1; i >= 0; i--) begin
         if (entry_vld[i] && (entry_key[i] == key)) begin
            match_hit    = 1'b1;
            match_action = entry_action[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         res_vld <= 1'b0;
         hit     <= 1'b0;
      end else begin
         res_vld <= key_vld;
         if (key_vld) begin
            hit <= match_hit;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (key_vld) begin
         action <= match_action;
      end
   end

endmodule

// ==== header_parser.sv ====
//////////////////////////////
// tracks word position and builds the flow key
//////////////////////////////
`timescale 1ns/100ps

module header_parser (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [opl_pkg::data_w-1:0] in_data,
   input  logic [opl_pkg::ctrl_w-1:0] in_ctrl,
   input  logic                       in_wr,
   output opl_pkg::flow_key_t         key,
   output logic                       key_vld
);

   import opl_pkg::*;

   // 0 header, 1 dst mac, 2 ethertype, 3 rest
   logic [1:0] word_cnt;
   logic       last_word;

   // end of packet, any nonzero ctrl except the header marker
   assign last_word = (in_ctrl != '0) && (in_ctrl != module_hdr_ctrl);

   //////////////////////////////
   // word position
   always_ff @(posedge clk) begin
      if (reset) begin
         word_cnt <= 2'd0;
         key_vld  <= 1'b0;
      end else begin
         // pulse once the ethertype word has gone in
         key_vld <= in_wr && (word_cnt == 2'd2);
         if (in_wr) begin
            if (last_word) begin
               word_cnt <= 2'd0;
            end else if (word_cnt != 2'd3) begin
               // saturate past the key words
               word_cnt <= word_cnt + 2'd1;
            end
         end
      end
   end

   //////////////////////////////
   // field capture
   always_ff @(posedge clk) begin
      if (in_wr) begin
         case (word_cnt)
            2'd0: key.src_port <= in_data[src_port_pos +: port_w];
            // dst mac fills the top six bytes
            2'd1: key.dst_mac <= in_data[data_w-1 -: mac_w];
            // ethertype after the two src mac bytes
            2'd2: key.ethertype <= in_data[16 +: type_w];
            default: key <= key;
         endcase
      end
   end

endmodule

// ==== match_arbiter.sv ====
//////////////////////////////
// picks exact over wildcard, queues one result per packet
//////////////////////////////
`timescale 1ns/100ps

module match_arbiter (
   input  logic             clk,
   input  logic             reset,
   input  logic             exact_hit,
   input  opl_pkg::action_t exact_action,
   input  logic             exact_vld,
   input  logic             wild_hit,
   input  opl_pkg::action_t wild_action,
   input  logic             res_rd_en,
   output logic             res_empty,
   output opl_pkg::action_t res_action,
   output logic             res_hit,
   output logic             res_nearly_full
);

   import opl_pkg::*;

   logic    pick_hit;
   action_t pick_action;

   // exact first, then wildcard, else a miss
   always_comb begin
      pick_hit    = exact_hit || wild_hit;
      pick_action = '0;
      if (exact_hit) begin
         pick_action = exact_action;
      end else if (wild_hit) begin
         pick_action = wild_action;
      end
   end

   // both matchers answer in the same cycle, exact_vld stands for both
   pkt_fifo #(
      .width      (num_ports + 1),
      .depth_bits (result_fifo_depth_bits)
   ) result_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         ({pick_hit, pick_action}),
      .wr_en       (exact_vld),
      .rd_en       (res_rd_en),
      .dout        ({res_hit, res_action}),
      .empty       (res_empty),
      .nearly_full (res_nearly_full)
   );

endmodule

// ==== opl_pkg.sv ====
//////////////////////////////
// output port lookup shared widths, header
// field positions, table sizes and codes
//////////////////////////////
package opl_pkg;

   //////////////////////////////
   // datapath words
   localparam int data_w = 64;
   localparam int ctrl_w = 8;

   // one output queue per bitmask bit
   localparam int num_ports = 8;

   //////////////////////////////
   // flow key fields
   localparam int port_w = 3;
   localparam int mac_w = 48;
   localparam int type_w = 16;
   localparam int key_w = port_w + mac_w + type_w;

   //////////////////////////////
   // module header word
   localparam logic [ctrl_w-1:0] module_hdr_ctrl = 8'hFF;

   // source port sits just above the packet length
   localparam int src_port_pos = 16;

   // output port bitmask in header bits 55:48
   localparam int dst_ports_pos = 48;

   //////////////////////////////
   // tables and queues
   localparam int exact_entries = 4;
   localparam int wildcard_entries = 4;
   localparam int table_idx_w = 2;

   // packet fifo holds a few full packets
   localparam int in_fifo_depth_bits = 5;

   // one entry per packet in flight
   localparam int result_fifo_depth_bits = 2;

   // processor fsm states
   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_forward = 2'd1;
   localparam logic [1:0] st_drop = 2'd2;

   //////////////////////////////
   // types
   typedef struct packed {
      logic [port_w-1:0] src_port;
      logic [mac_w-1:0]  dst_mac;
      logic [type_w-1:0] ethertype;
   } flow_key_t;

   typedef logic [num_ports-1:0] action_t;

endpackage

// ==== opl_processor.sv ====
//////////////////////////////
// pairs actions with packets, rewrites header, forwards or drops
//////////////////////////////
`timescale 1ns/100ps

module opl_processor (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [opl_pkg::data_w-1:0] in_fifo_data,
   input  logic [opl_pkg::ctrl_w-1:0] in_fifo_ctrl,
   input  logic                       in_fifo_empty,
   output logic                       in_fifo_rd_en,
   input  logic                       res_empty,
   input  opl_pkg::action_t           res_action,
   input  logic                       res_hit,
   output logic                       res_rd_en,
   output logic [opl_pkg::data_w-1:0] out_data,
   output logic [opl_pkg::ctrl_w-1:0] out_ctrl,
   output logic                       out_wr,
   input  logic                       out_rdy,
   output logic [15:0]                drop_count
);

   import opl_pkg::*;

   logic [1:0]        state;
   // header word still at the fifo head
   logic              first_word;
   action_t           act_q;
   logic              last_word;
   logic              pkt_drop;
   logic [data_w-1:0] hdr_word;

   assign last_word = (in_fifo_ctrl != '0) && (in_fifo_ctrl != module_hdr_ctrl);

   // miss or empty bitmask goes nowhere
   assign pkt_drop = !res_hit || (res_action == '0);

   // header at the head and its result ready
   assign res_rd_en = (state == st_idle) && !in_fifo_empty && !res_empty;

   //////////////////////////////
   // datapath
   // new output ports over the old field
   always_comb begin
      hdr_word = in_fifo_data;
      hdr_word[dst_ports_pos +: num_ports] = act_q;
   end

   assign out_wr   = (state == st_forward) && !in_fifo_empty && out_rdy;
   assign out_data = first_word ? hdr_word : in_fifo_data;
   assign out_ctrl = in_fifo_ctrl;

   // drop drains one word a cycle, out_rdy ignored
   assign in_fifo_rd_en = out_wr || ((state == st_drop) && !in_fifo_empty);

   //////////////////////////////
   // fsm
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_idle;
         first_word <= 1'b0;
         drop_count <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (res_rd_en) begin
                  first_word <= 1'b1;
                  if (pkt_drop) begin
                     state      <= st_drop;
                     drop_count <= drop_count + 16'd1;
                  end else begin
                     state <= st_forward;
                  end
               end
            end
            st_forward: begin
               if (out_wr) begin
                  first_word <= 1'b0;
                  if (last_word) begin
                     state <= st_idle;
                  end
               end
            end
            st_drop: begin
               if (in_fifo_rd_en && last_word) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // action held for the header rewrite
   always_ff @(posedge clk) begin
      if (res_rd_en) begin
         act_q <= res_action;
      end
   end

endmodule

// ==== output_port_lookup.sv ====
//////////////////////////////
// output port lookup stage, top level
//////////////////////////////
`timescale 1ns/100ps

module output_port_lookup (
   input  logic                            clk,
   input  logic                            reset,
   // packet input
   input  logic [opl_pkg::data_w-1:0]      in_data,
   input  logic [opl_pkg::ctrl_w-1:0]      in_ctrl,
   input  logic                            in_wr,
   output logic                            in_rdy,
   // packet output
   output logic [opl_pkg::data_w-1:0]      out_data,
   output logic [opl_pkg::ctrl_w-1:0]      out_ctrl,
   output logic                            out_wr,
   input  logic                            out_rdy,
   // table write port
   input  logic                            tbl_wr,
   input  logic                            tbl_wildcard,
   input  logic [opl_pkg::table_idx_w-1:0] tbl_index,
   input  opl_pkg::flow_key_t              tbl_key,
   input  opl_pkg::flow_key_t              tbl_mask,
   input  opl_pkg::action_t                tbl_action,
   output logic [15:0]                     drop_count
);

   import opl_pkg::*;

   // input fifo head
   logic [data_w-1:0] in_fifo_data;
   logic [ctrl_w-1:0] in_fifo_ctrl;
   logic              in_fifo_empty;
   logic              in_fifo_rd_en;
   logic              in_nearly_full;

   // parser to matchers
   flow_key_t key;
   logic      key_vld;

   // matchers to arbiter
   logic    exact_hit;
   action_t exact_action;
   logic    exact_vld;
   logic    wild_hit;
   action_t wild_action;

   // arbiter to processor
   logic    res_empty;
   action_t res_action;
   logic    res_hit;
   logic    res_rd_en;
   logic    res_nearly_full;

   // stop the source when either queue runs short
   assign in_rdy = !(in_nearly_full || res_nearly_full);

   //////////////////////////////
   // packet storage and parsing
   pkt_fifo #(
      .width      (ctrl_w + data_w),
      .depth_bits (in_fifo_depth_bits)
   ) input_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         ({in_ctrl, in_data}),
      .wr_en       (in_wr),
      .rd_en       (in_fifo_rd_en),
      .dout        ({in_fifo_ctrl, in_fifo_data}),
      .empty       (in_fifo_empty),
      .nearly_full (in_nearly_full)
   );

   header_parser header_parser (
      .clk     (clk),
      .reset   (reset),
      .in_data (in_data),
      .in_ctrl (in_ctrl),
      .in_wr   (in_wr),
      .key     (key),
      .key_vld (key_vld)
   );

   //////////////////////////////
   // lookup, both tables in parallel
   exact_match exact_match (
      .clk          (clk),
      .reset        (reset),
      .key          (key),
      .key_vld      (key_vld),
      .tbl_wr       (tbl_wr),
      .tbl_wildcard (tbl_wildcard),
      .tbl_index    (tbl_index),
      .tbl_key      (tbl_key),
      .tbl_action   (tbl_action),
      .hit          (exact_hit),
      .action       (exact_action),
      .res_vld      (exact_vld)
   );

   // valid is aligned with the exact result
   wildcard_match wildcard_match (
      .clk          (clk),
      .reset        (reset),
      .key          (key),
      .key_vld      (key_vld),
      .tbl_wr       (tbl_wr),
      .tbl_wildcard (tbl_wildcard),
      .tbl_index    (tbl_index),
      .tbl_key      (tbl_key),
      .tbl_mask     (tbl_mask),
      .tbl_action   (tbl_action),
      .hit          (wild_hit),
      .action       (wild_action),
      .res_vld      ()
   );

   match_arbiter match_arbiter (
      .clk             (clk),
      .reset           (reset),
      .exact_hit       (exact_hit),
      .exact_action    (exact_action),
      .exact_vld       (exact_vld),
      .wild_hit        (wild_hit),
      .wild_action     (wild_action),
      .res_rd_en       (res_rd_en),
      .res_empty       (res_empty),
      .res_action      (res_action),
      .res_hit         (res_hit),
      .res_nearly_full (res_nearly_full)
   );

   //////////////////////////////
   // header rewrite and output
   opl_processor opl_processor (
      .clk           (clk),
      .reset         (reset),
      .in_fifo_data  (in_fifo_data),
      .in_fifo_ctrl  (in_fifo_ctrl),
      .in_fifo_empty (in_fifo_empty),
      .in_fifo_rd_en (in_fifo_rd_en),
      .res_empty     (res_empty),
      .res_action    (res_action),
      .res_hit       (res_hit),
      .res_rd_en     (res_rd_en),
      .out_data      (out_data),
      .out_ctrl      (out_ctrl),
      .out_wr        (out_wr),
      .out_rdy       (out_rdy),
      .drop_count    (drop_count)
   );

endmodule

// ==== pkt_fifo.sv ====
//////////////////////////////
// first-word-fall-through fifo with nearly-full flag
//////////////////////////////
`timescale 1ns/100ps

module pkt_fifo #(
   parameter int width = 72,
   parameter int depth_bits = 5
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [width-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [width-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   // word storage
   logic [width-1:0] mem [2**depth_bits];

   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   // one extra bit so full and empty differ
   logic [depth_bits:0]   count;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head word shows without a read
   assign dout = mem[rd_ptr];
   assign empty = (count == '0);

   // two slots left leave room for the word already on its way
   assign nearly_full = (count >= (depth_bits + 1)'(2**depth_bits - 2));

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the output port lookup testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_output_port_lookup -o sim_opl
./obj_dir/sim_opl | tee sim.log
if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported errors"
   exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

// ==== tb_output_port_lookup.sv ====
//////////////////////////////
// output port lookup testbench, table programming,
// packet table, output checker and watchdog
//////////////////////////////
`timescale 1ns/100ps

module tb_output_port_lookup;

   import opl_pkg::*;

   logic                   clk;
   logic                   reset;
   logic [data_w-1:0]      in_data;
   logic [ctrl_w-1:0]      in_ctrl;
   logic                   in_wr;
   logic                   in_rdy;
   logic [data_w-1:0]      out_data;
   logic [ctrl_w-1:0]      out_ctrl;
   logic                   out_wr;
   logic                   out_rdy;
   logic                   tbl_wr;
   logic                   tbl_wildcard;
   logic [table_idx_w-1:0] tbl_index;
   flow_key_t              tbl_key;
   flow_key_t              tbl_mask;
   action_t                tbl_action;
   logic [15:0]            drop_count;

   // packet rows where action 0 means a drop
   string             row_name [$];
   logic [port_w-1:0] row_port [$];
   logic [mac_w-1:0]  row_mac [$];
   logic [type_w-1:0] row_type [$];
   int                row_len [$];
   action_t           row_act [$];

   // expected output words with ctrl on top
   logic [ctrl_w+data_w-1:0] exp_word [$];
   string                    exp_name [$];

   int                       errors;
   int                       checked;
   logic [15:0]              drops_exp;
   logic [ctrl_w+data_w-1:0] got;
   logic [ctrl_w+data_w-1:0] want;
   string                    cur_name;

   output_port_lookup output_port_lookup_i (.*);

   always #5 clk = ~clk;

   // random sink back-pressure
   task automatic drive_ready();
      forever begin
         @(posedge clk);
         #1;
         out_rdy = (($urandom % 4) != 0);
      end
   endtask

   task automatic add_row(input string name, input logic [port_w-1:0] port,
                          input logic [mac_w-1:0] mac, input logic [type_w-1:0] etype,
                          input int len, input action_t act);
      row_name.push_back(name);
      row_port.push_back(port);
      row_mac.push_back(mac);
      row_type.push_back(etype);
      row_len.push_back(len);
      row_act.push_back(act);
   endtask

   task automatic write_entry(input logic wild, input logic [table_idx_w-1:0] idx,
                              input flow_key_t key, input flow_key_t mask,
                              input action_t act);
      tbl_wr       = 1'b1;
      tbl_wildcard = wild;
      tbl_index    = idx;
      tbl_key      = key;
      tbl_mask     = mask;
      tbl_action   = act;
      @(posedge clk);
      #1;
      tbl_wr = 1'b0;
   endtask

   // one word once the stage has room
   task automatic send_word(input logic [data_w-1:0] d, input logic [ctrl_w-1:0] c);
      while (!in_rdy) begin
         @(posedge clk);
         #1;
      end
      in_data = d;
      in_ctrl = c;
      in_wr   = 1'b1;
      @(posedge clk);
      #1;
      in_wr = 1'b0;
   endtask

   task automatic send_packet(input int idx);
      logic [data_w-1:0] word;
      logic [data_w-1:0] exp;
      logic [ctrl_w-1:0] ctrl;
      int                len;
      len = row_len[idx];
      for (int w = 0; w < len; w++) begin
         word = {$urandom, $urandom};
         ctrl = 8'h00;
         if (w == 0) begin
            word[src_port_pos +: port_w] = row_port[idx];
            ctrl = module_hdr_ctrl;
         end else if (w == 1) begin
            word[63:16] = row_mac[idx];
         end else if (w == 2) begin
            word[31:16] = row_type[idx];
         end
         // last word carries one byte-valid bit
         if (w == len - 1) begin
            ctrl = 8'h01 << ($urandom % 8);
         end
         if (row_act[idx] != '0) begin
            exp = word;
            // header carries the new output ports
            if (w == 0) begin
               exp[dst_ports_pos +: num_ports] = row_act[idx];
            end
            exp_word.push_back({ctrl, exp});
            exp_name.push_back(row_name[idx]);
         end
         send_word(word, ctrl);
      end
   endtask

   //////////////////////////////
   // output checker
   // output words compared at the falling edge
   always @(negedge clk) begin
      if (!reset && out_wr) begin
         assert (exp_word.size() > 0) else begin
            errors++;
            $display("output word %h appeared with no packet expected", {out_ctrl, out_data});
         end
         if (exp_word.size() > 0) begin
            got      = {out_ctrl, out_data};
            want     = exp_word.pop_front();
            cur_name = exp_name.pop_front();
            checked++;
            assert (got == want) else begin
               errors++;
               $display("FAIL %s expected %h actual %h", cur_name, want, got);
            end
         end
      end
   end

   //////////////////////////////
   // main sequence
   initial begin
      void'($urandom(92550));
      clk          = 1'b0;
      reset        = 1'b1;
      in_data      = '0;
      in_ctrl      = '0;
      in_wr        = 1'b0;
      out_rdy      = 1'b0;
      tbl_wr       = 1'b0;
      tbl_wildcard = 1'b0;
      tbl_index    = '0;
      tbl_key      = '0;
      tbl_mask     = '0;
      tbl_action   = '0;
      errors       = 0;
      checked      = 0;
      drops_exp    = '0;

      fork
         drive_ready();
      join_none

      // exact hits, miss and zero action, then back to back
      add_row("exact_hit", 3'd1, 48'h001122334455, 16'h0800, 5, 8'h04);
      add_row("exact_arp", 3'd2, 48'h00AABBCCDDEE, 16'h0806, 4, 8'h10);
      add_row("wild_mac_mask", 3'd5, 48'h02000000007F, 16'h0800, 6, 8'h20);
      add_row("wild_any_mac", 3'd4, 48'h0A0B0C0D0E0F, 16'h0800, 3, 8'h40);
      add_row("wild_port", 3'd0, 48'h123456789ABC, 16'h86DD, 7, 8'h81);
      add_row("miss_type", 3'd0, 48'h00AABBCCDDEE, 16'h0806, 4, 8'h00);
      add_row("miss_port", 3'd1, 48'h123456789ABC, 16'h86DD, 5, 8'h00);
      add_row("zero_action", 3'd3, 48'h001122334466, 16'h0800, 4, 8'h00);
      add_row("exact_over_wild", 3'd6, 48'h020000000011, 16'h0800, 8, 8'h02);
      add_row("wild_lowest", 3'd7, 48'h020000000011, 16'h0800, 4, 8'h20);
      add_row("miss_mac", 3'd2, 48'h00AABBCCDDEF, 16'h0806, 5, 8'h00);
      add_row("b2b_long", 3'd0, 48'h123456789ABC, 16'h86DD, 12, 8'h81);
      add_row("b2b_exact", 3'd2, 48'h00AABBCCDDEE, 16'h0806, 3, 8'h10);
      add_row("b2b_wild", 3'd3, 48'h0A0B0C0D0E0F, 16'h0800, 9, 8'h40);

      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      // exact table where entry 2 has an empty bitmask
      write_entry(1'b0, 2'd0, {3'd1, 48'h001122334455, 16'h0800}, '0, 8'h04);
      write_entry(1'b0, 2'd1, {3'd2, 48'h00AABBCCDDEE, 16'h0806}, '0, 8'h10);
      write_entry(1'b0, 2'd2, {3'd3, 48'h001122334466, 16'h0800}, '0, 8'h00);
      write_entry(1'b0, 2'd3, {3'd6, 48'h020000000011, 16'h0800}, '0, 8'h02);
      // wildcard entries 0 and 1 overlap
      write_entry(1'b1, 2'd0, {3'd0, 48'h020000000000, 16'h0800},
                  {3'b111, 48'h0000000000FF, 16'h0000}, 8'h20);
      write_entry(1'b1, 2'd1, {3'd0, 48'h000000000000, 16'h0800},
                  {3'b111, 48'hFFFFFFFFFFFF, 16'h0000}, 8'h40);
      write_entry(1'b1, 2'd2, {3'd0, 48'h000000000000, 16'h86DD},
                  {3'b000, 48'hFFFFFFFFFFFF, 16'h0000}, 8'h81);

      foreach (row_name[i]) begin
         send_packet(i);
         if (row_act[i] == '0) begin
            drops_exp = drops_exp + 16'd1;
         end
      end

      // last row forwards, so every drop is counted by then
      while (exp_word.size() != 0) begin
         @(posedge clk);
      end
      // quiet period to catch stray words
      repeat (20) @(posedge clk);

      assert (drop_count == drops_exp) else begin
         errors++;
         $display("FAIL drop_count expected %0d actual %0d", drops_exp, drop_count);
      end

      $display("errors: %0d, words checked: %0d", errors, checked);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   //////////////////////////////
   // watchdog allows 200 cycles per packet row
   initial begin
      repeat (10) @(posedge clk);
      repeat (row_name.size() * 200) @(posedge clk);
      $display("watchdog expired with %0d output words still missing", exp_word.size());
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== wildcard_match.sv ====
//////////////////////////////
// masked flow table, per-bit don't care
//////////////////////////////
`timescale 1ns/100ps

module wildcard_match (
   input  logic                            clk,
   input  logic                            reset,
   input  opl_pkg::flow_key_t              key,
   input  logic                            key_vld,
   input  logic                            tbl_wr,
   input  logic                            tbl_wildcard,
   input  logic [opl_pkg::table_idx_w-1:0] tbl_index,
   input  opl_pkg::flow_key_t              tbl_key,
   input  opl_pkg::flow_key_t              tbl_mask,
   input  opl_pkg::action_t                tbl_action,
   output logic                            hit,
   output opl_pkg::action_t                action,
   output logic                            res_vld
);

   import opl_pkg::*;

   logic [wildcard_entries-1:0] entry_vld;
   flow_key_t                   entry_key [wildcard_entries];
   // mask bit set means ignore that key bit
   logic [key_w-1:0]            entry_mask [wildcard_entries];
   action_t                     entry_action [wildcard_entries];

   logic    match_hit;
   action_t match_action;
   logic    tbl_sel;

   assign tbl_sel = tbl_wr && tbl_wildcard;

   //////////////////////////////
   // table storage
   always_ff @(posedge clk) begin
      if (reset) begin
         entry_vld <= '0;
      end else if (tbl_sel) begin
         entry_vld[tbl_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (tbl_sel) begin
         entry_key[tbl_index]    <= tbl_key;
         entry_mask[tbl_index]   <= tbl_mask;
         entry_action[tbl_index] <= tbl_action;
      end
   end

   //////////////////////////////
   // search
   // only unmasked bits compare; lowest index wins
   always_comb begin
      match_hit    = 1'b0;
      match_action = '0;
      for (int i = wildcard_entries - 1; i >= 0; i--) begin
         if (entry_vld[i] && (((entry_key[i] ^ key) & ~entry_mask[i]) == '0)) begin
            match_hit    = 1'b1;
            match_action = entry_action[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         res_vld <= 1'b0;
         hit     <= 1'b0;
      end else begin
         res_vld <= key_vld;
         if (key_vld) begin
            hit <= match_hit;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (key_vld) begin
         action <= match_action;
      end
   end

endmodule
